//--- verilog/dcachePkg.sv
// Cache geometry and address split helpers
// Request, lookup and command structs, controller states
`default_nettype none

package dcachePkg;

    // ------------------------------
    // Geometry
    // ------------------------------
    localparam int NUM_WAYS    = 2;
    localparam int NUM_SETS    = 4;
    localparam int BLOCK_WORDS = 4;
    localparam int WORD_BYTES  = 4;

    // Address split, tag above set above word above byte
    localparam int WAY_BITS  = $clog2(NUM_WAYS);
    localparam int SET_BITS  = $clog2(NUM_SETS);
    localparam int WORD_BITS = $clog2(BLOCK_WORDS);
    localparam int BYTE_BITS = $clog2(WORD_BYTES);
    localparam int TAG_BITS  = 32 - SET_BITS - WORD_BITS - BYTE_BITS;

    // ------------------------------
    // Types
    // ------------------------------

    // One processor access
    typedef struct packed {
        logic [31:0]           addr;
        logic [31:0]           wData;
        logic [WORD_BYTES-1:0] byteMask;
        logic                  isWrite;
    } cpuReqT;

    // Captured request plus the tag lookup result
    typedef struct packed {
        logic                 valid;
        cpuReqT               req;
        logic [SET_BITS-1:0]  set;
        logic [TAG_BITS-1:0]  tag;
        logic [WORD_BITS-1:0] wordIdx;
        logic                 hit;
        logic [WAY_BITS-1:0]  hitWay;
        logic [WAY_BITS-1:0]  victimWay;
        logic                 victimDirty;
        logic [TAG_BITS-1:0]  victimTag;
    } lookupT;

    // Update to the tag, valid, dirty and LRU arrays
    typedef struct packed {
        logic                we;
        logic [WAY_BITS-1:0] way;
        logic [SET_BITS-1:0] set;
        logic [TAG_BITS-1:0] tag;
        logic                setValid;
        logic                setDirty;
        logic                touchLru;
    } tagCmdT;

    // Write port and read select for the block storage
    typedef struct packed {
        logic                  we;
        logic [WAY_BITS-1:0]   way;
        logic [SET_BITS-1:0]   set;
        logic [WORD_BITS-1:0]  wordIdx;
        logic [31:0]           wData;
        logic [WORD_BYTES-1:0] byteMask;
        logic [WAY_BITS-1:0]   rdWay;
        logic [WORD_BITS-1:0]  rdWord;
    } dataCmdT;

    // Miss handling states
    typedef enum logic [1:0] {
        S_LOOKUP,
        S_WRITEBACK,
        S_FILL,
        S_FINISH
    } ctrlStateT;

    // ------------------------------
    // Address helpers
    // ------------------------------
    function automatic logic [TAG_BITS-1:0] addrTag(input logic [31:0] addr);
        return addr[31 -: TAG_BITS];
    endfunction

    function automatic logic [SET_BITS-1:0] addrSet(input logic [31:0] addr);
        return addr[BYTE_BITS + WORD_BITS +: SET_BITS];
    endfunction

    function automatic logic [WORD_BITS-1:0] addrWord(input logic [31:0] addr);
        return addr[BYTE_BITS +: WORD_BITS];
    endfunction

    // Word address on the bus, byte offset always zero
    function automatic logic [31:0] blockAddr(input logic [TAG_BITS-1:0]  tag,
                                              input logic [SET_BITS-1:0]  set,
                                              input logic [WORD_BITS-1:0] word);
        return {tag, set, word, {BYTE_BITS{1'b0}}};
    endfunction

endpackage

`default_nettype wire

//--- verilog/dcacheTagStage.sv
// Request register and tag/valid/dirty/LRU arrays
// Hit detection and victim choice for the captured set
`timescale 1ns/1ps
`default_nettype none

module dcacheTagStage
    import dcachePkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   req,
    input  cpuReqT reqData,
    input  logic   invalidate,
    input  logic   stall,
    input  tagCmdT tagCmd,
    output lookupT lookup
);

    // Captured request
    cpuReqT reqReg;
    logic   reqValid;

    // Per way, per set state
    logic [TAG_BITS-1:0]               tagArr [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] validArr;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirtyArr;
    // LRU bit names the least recently used way
    logic [NUM_SETS-1:0]               lruArr;

    // Lookup signals
    logic [SET_BITS-1:0] curSet;
    logic [TAG_BITS-1:0] curTag;
    logic [NUM_WAYS-1:0] wayHit;
    logic [WAY_BITS-1:0] hitWay;
    logic [WAY_BITS-1:0] victimWay;

    // ------------------------------
    // Request capture
    // ------------------------------

    // Accept only when not stalled, hold otherwise
    always_ff @(posedge clk) begin
        if (!rstN) begin
            reqValid <= 1'b0;
        end else if (!stall) begin
            reqValid <= req;
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (req && !stall) begin
            reqReg <= reqData;
        end
    end

    assign curSet = addrSet(reqReg.addr);
    assign curTag = addrTag(reqReg.addr);

    // ------------------------------
    // Lookup
    // ------------------------------
    always_comb begin
        hitWay = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            wayHit[w] = validArr[w][curSet] && (tagArr[w][curSet] == curTag);
            if (wayHit[w]) begin
                hitWay = WAY_BITS'(w);
            end
        end
    end

    // Lowest invalid way first, else the LRU way
    always_comb begin
        victimWay = lruArr[curSet];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!validArr[w][curSet]) begin
                victimWay = WAY_BITS'(w);
            end
        end
    end

    always_comb begin
        lookup             = '0;
        lookup.valid       = reqValid;
        lookup.req         = reqReg;
        lookup.set         = curSet;
        lookup.tag         = curTag;
        lookup.wordIdx     = addrWord(reqReg.addr);
        lookup.hit         = |wayHit;
        lookup.hitWay      = hitWay;
        lookup.victimWay   = victimWay;
        // Invalid ways are never dirty
        lookup.victimDirty = validArr[victimWay][curSet] && dirtyArr[victimWay][curSet];
        lookup.victimTag   = tagArr[victimWay][curSet];
    end

    // ------------------------------
    // Array updates
    // ------------------------------
    always_ff @(posedge clk) begin
        if (tagCmd.we) begin
            tagArr[tagCmd.way][tagCmd.set] <= tagCmd.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validArr <= '0;
            dirtyArr <= '0;
            lruArr   <= '0;
        end else begin
            if (tagCmd.we) begin
                validArr[tagCmd.way][tagCmd.set] <= tagCmd.setValid;
                dirtyArr[tagCmd.way][tagCmd.set] <= tagCmd.setDirty;
            end
            // Other way becomes LRU
            if (tagCmd.touchLru) begin
                lruArr[tagCmd.set] <= ~tagCmd.way;
            end
            // Flush wins over any same-cycle update, dirty lines dropped
            if (invalidate && !stall) begin
                validArr <= '0;
                dirtyArr <= '0;
            end
        end
    end

    // Controller only fills on a miss, so no tag is ever held twice in a set
    assert property (@(posedge clk) disable iff (!rstN) reqValid |-> $onehot0(wayHit));

endmodule

`default_nettype wire

//--- verilog/dcacheController.sv
// Miss handling FSM with word counter and bus outputs
// Stall, done and the tag and data commands
`timescale 1ns/1ps
`default_nettype none

module dcacheController
    import dcachePkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  lookupT      lookup,
    input  logic [31:0] rdWord,
    input  logic        busReady,
    input  logic [31:0] busRData,
    output tagCmdT      tagCmd,
    output dataCmdT     dataCmd,
    output logic        stall,
    output logic        done,
    output logic [31:0] rdData,
    output logic        busRequest,
    output logic        busWrite,
    output logic [31:0] busAddr,
    output logic [31:0] busWData
);

    ctrlStateT            state;
    ctrlStateT            nextState;
    logic [WORD_BITS-1:0] wordCnt;
    logic                 lastWord;
    logic                 missNow;
    logic                 hitNow;
    logic                 beat;

    // ------------------------------
    // Status decode
    // ------------------------------
    assign missNow = (state == S_LOOKUP) && lookup.valid && !lookup.hit;

    // Finish replays the access on the freshly filled way
    assign hitNow = ((state == S_LOOKUP) && lookup.valid && lookup.hit) ||
                    (state == S_FINISH);

    assign lastWord = (wordCnt == WORD_BITS'(BLOCK_WORDS - 1));

    // One word moves on the bus
    assign beat = busRequest && busReady;

    // ------------------------------
    // FSM
    // ------------------------------
    always_comb begin
        nextState = state;
        case (state)
            S_LOOKUP: begin
                if (missNow) begin
                    nextState = lookup.victimDirty ? S_WRITEBACK : S_FILL;
                end
            end
            S_WRITEBACK: begin
                if (busReady && lastWord) begin
                    nextState = S_FILL;
                end
            end
            S_FILL: begin
                if (busReady && lastWord) begin
                    nextState = S_FINISH;
                end
            end
            S_FINISH: begin
                nextState = S_LOOKUP;
            end
            default: begin
                nextState = S_LOOKUP;
            end
        endcase
    end

    // Counter wraps to zero between write-back and fill
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= S_LOOKUP;
            wordCnt <= '0;
        end else begin
            state <= nextState;
            if (missNow) begin
                wordCnt <= '0;
            end else if (beat) begin
                wordCnt <= wordCnt + 1'b1;
            end
        end
    end

    // ------------------------------
    // Processor and bus outputs
    // ------------------------------
    assign busRequest = (state == S_WRITEBACK) || (state == S_FILL);
    assign busWrite   = (state == S_WRITEBACK);
    assign stall      = missNow || busRequest;
    assign done       = hitNow;
    assign rdData     = rdWord;
    // Victim word read out during write-back
    assign busWData   = rdWord;

    // Old line address on write-back, requested line on fill
    assign busAddr = busWrite ? blockAddr(lookup.victimTag, lookup.set, wordCnt)
                              : blockAddr(lookup.tag, lookup.set, wordCnt);

    // ------------------------------
    // Tag and data commands
    // ------------------------------
    always_comb begin
        // Defaults aim at the hit way
        tagCmd          = '0;
        tagCmd.way      = lookup.hitWay;
        tagCmd.set      = lookup.set;
        tagCmd.tag      = lookup.tag;
        dataCmd          = '0;
        dataCmd.way      = lookup.hitWay;
        dataCmd.set      = lookup.set;
        dataCmd.wordIdx  = lookup.wordIdx;
        dataCmd.wData    = lookup.req.wData;
        dataCmd.byteMask = lookup.req.byteMask;
        dataCmd.rdWay    = lookup.hitWay;
        dataCmd.rdWord   = lookup.wordIdx;

        case (state)
            S_WRITEBACK: begin
                dataCmd.rdWay  = lookup.victimWay;
                dataCmd.rdWord = wordCnt;
            end
            S_FILL: begin
                // Whole words from the bus into the victim way
                dataCmd.we       = busReady;
                dataCmd.way      = lookup.victimWay;
                dataCmd.wordIdx  = wordCnt;
                dataCmd.wData    = busRData;
                dataCmd.byteMask = '1;
                // New tag lands with the last word, line clean
                if (busReady && lastWord) begin
                    tagCmd.we       = 1'b1;
                    tagCmd.way      = lookup.victimWay;
                    tagCmd.setValid = 1'b1;
                    tagCmd.setDirty = 1'b0;
                end
            end
            default: begin
            end
        endcase

        // Hits touch LRU, stores merge bytes and mark dirty
        if (hitNow) begin
            tagCmd.touchLru = 1'b1;
            tagCmd.we       = lookup.req.isWrite;
            tagCmd.setValid = 1'b1;
            tagCmd.setDirty = 1'b1;
            dataCmd.we      = lookup.req.isWrite;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // Bus only runs for a held request that still misses
    assert property (@(posedge clk) disable iff (!rstN)
                     busRequest |-> lookup.valid && !lookup.hit);

    assert property (@(posedge clk) disable iff (!rstN) done |-> !stall);

    // Tag write at the last fill beat must show up as a hit in finish
    assert property (@(posedge clk) disable iff (!rstN) state == S_FINISH |-> lookup.hit);

    // Bus address held until the word is taken
    assert property (@(posedge clk) disable iff (!rstN)
                     busRequest && !busReady |=> $stable(busAddr));

endmodule

`default_nettype wire

//--- verilog/dcacheDataStage.sv
// Two-way block storage in flip-flops
// Byte-masked word writes and combinational word read
`timescale 1ns/1ps
`default_nettype none

module dcacheDataStage
    import dcachePkg::*;
(
    input  logic        clk,
    input  dataCmdT     dataCmd,
    output logic [31:0] rdWord
);

    // ------------------------------
    // Storage
    // ------------------------------

    // Way, set, word
    logic [31:0] blockMem [NUM_WAYS][NUM_SETS][BLOCK_WORDS];

    // Current content of the word being written
    logic [31:0] oldWord;

    // Old word with masked bytes replaced
    logic [31:0] mergedWord;

    // ------------------------------
    // Write path
    // ------------------------------
    assign oldWord = blockMem[dataCmd.way][dataCmd.set][dataCmd.wordIdx];

    // Byte lane select
    always_comb begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (dataCmd.byteMask[b]) begin
                mergedWord[b*8 +: 8] = dataCmd.wData[b*8 +: 8];
            end else begin
                mergedWord[b*8 +: 8] = oldWord[b*8 +: 8];
            end
        end
    end

    // Fill writes carry a full mask, stores their own
    always_ff @(posedge clk) begin
        if (dataCmd.we) begin
            blockMem[dataCmd.way][dataCmd.set][dataCmd.wordIdx] <= mergedWord;
        end
    end

    // ------------------------------
    // Read path
    // ------------------------------

    // Same port serves hit reads and write-back words
    assign rdWord = blockMem[dataCmd.rdWay][dataCmd.set][dataCmd.rdWord];

    // ------------------------------
    // Checks
    // ------------------------------

    // An empty mask would mark a line dirty with nothing written
    assert property (@(posedge clk) dataCmd.we |-> dataCmd.byteMask != '0);

endmodule

`default_nettype wire

//--- verilog/dcacheTop.sv
// Data cache top level
// Tag stage, controller and data stage wiring
`timescale 1ns/1ps
`default_nettype none

module dcacheTop
    import dcachePkg::*;
(
    // Processor side
    input  logic        clk,
    input  logic        rstN,
    input  logic        req,
    input  cpuReqT      reqData,
    input  logic        invalidate,
    output logic        stall,
    output logic        done,
    output logic [31:0] rdData,
    // Memory bus
    output logic        busRequest,
    output logic        busWrite,
    output logic [31:0] busAddr,
    output logic [31:0] busWData,
    input  logic        busReady,
    input  logic [31:0] busRData
);

    // Stage links
    lookupT      lookup;
    tagCmdT      tagCmd;
    dataCmdT     dataCmd;
    logic [31:0] rdWord;

    // Request capture and tag lookup
    dcacheTagStage u_tagStage (
        .clk        (clk),
        .rstN       (rstN),
        .req        (req),
        .reqData    (reqData),
        .invalidate (invalidate),
        .stall      (stall),
        .tagCmd     (tagCmd),
        .lookup     (lookup)
    );

    // Hit and miss sequencing
    dcacheController u_controller (
        .clk        (clk),
        .rstN       (rstN),
        .lookup     (lookup),
        .rdWord     (rdWord),
        .busReady   (busReady),
        .busRData   (busRData),
        .tagCmd     (tagCmd),
        .dataCmd    (dataCmd),
        .stall      (stall),
        .done       (done),
        .rdData     (rdData),
        .busRequest (busRequest),
        .busWrite   (busWrite),
        .busAddr    (busAddr),
        .busWData   (busWData)
    );

    // Block storage
    dcacheDataStage u_dataStage (
        .clk     (clk),
        .dataCmd (dataCmd),
        .rdWord  (rdWord)
    );

endmodule

`default_nettype wire

//--- testbench/busMemModel.sv
// Word-wide bus memory with random ready delays
// Backdoor word read and a log of bus writes
`timescale 1ns/1ps
`default_nettype none

module busMemModel (
    input  logic        clk,
    input  logic        rstN,
    input  logic        busRequest,
    input  logic        busWrite,
    input  logic [31:0] busAddr,
    input  logic [31:0] busWData,
    output logic        busReady,
    output logic [31:0] busRData
);

    localparam int MEM_WORDS = 256;
    localparam int MAX_WAIT  = 2;

    logic [31:0] mem [MEM_WORDS];
    int          waitCnt;
    integer      delaySeed;

    // Bus writes in order, drained by the testbench
    logic [31:0] logAddr [$];
    logic [31:0] logData [$];

    // Backdoor read, byte offset ignored
    function automatic logic [31:0] peekWord(input logic [31:0] addr);
        return mem[addr[9:2]];
    endfunction

    initial begin
        logic        rstNow;
        logic        beatNow;
        logic        reqNow;
        logic        wrNow;
        logic [31:0] addrNow;
        logic [31:0] dataNow;
        // Fill pattern mixes every address bit
        for (int i = 0; i < MEM_WORDS; i++) begin
            addrNow = 32'(i) << 2;
            mem[i]  = addrNow ^ {addrNow[15:0], addrNow[31:16]} ^ 32'hC3A5_0F96;
        end
        delaySeed = 47;
        waitCnt   = 0;
        busReady  = 1'b0;
        busRData  = '0;
        forever begin
            @(posedge clk);
            // Sample the bus at the edge
            rstNow  = rstN;
            beatNow = busReady;
            reqNow  = busRequest;
            wrNow   = busWrite;
            addrNow = busAddr;
            dataNow = busWData;
            #1;
            if (!rstNow) begin
                busReady = 1'b0;
                waitCnt  = 0;
            end else if (beatNow) begin
                // One word moved at this edge
                if (wrNow) begin
                    mem[addrNow[9:2]] = dataNow;
                    logAddr.push_back(addrNow);
                    logData.push_back(dataNow);
                end
                busReady = 1'b0;
                waitCnt  = ($random(delaySeed) & 32'h7fff_ffff) % (MAX_WAIT + 1);
            end else if (reqNow) begin
                if (waitCnt == 0) begin
                    busReady = 1'b1;
                    busRData = mem[addrNow[9:2]];
                end else begin
                    waitCnt--;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/dcacheTb.sv
// Data cache testbench with shadow memory model
// Directed hit, LRU, invalidate and reset checks, random accesses, final sweep
`timescale 1ns/1ps
`default_nettype none

module dcacheTb
    import dcachePkg::*;
();

    localparam int NUM_RANDOM   = 1400;
    localparam int NUM_ACCESSES = 1500;
    // Accesses x transfers per miss x cycles per transfer, doubled, plus slack
    localparam int MAX_CYCLES   = NUM_ACCESSES * 2 * BLOCK_WORDS * 4 * 2 + 4000;

    logic        clk;
    logic        rstN;
    logic        req;
    cpuReqT      reqData;
    logic        invalidate;
    logic        stall;
    logic        done;
    logic [31:0] rdData;
    logic        busRequest;
    logic        busWrite;
    logic [31:0] busAddr;
    logic [31:0] busWData;
    logic        busReady;
    logic [31:0] busRData;

    // Byte image of what reads must return
    logic [7:0]  shadow [1024];
    integer      seed;
    int          cycleCount = 0;

    dcacheTop u_dut (.*);

    busMemModel busMem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // Checks and shadow helpers
    // ------------------------------
    task automatic reportFailure;
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            reportFailure();
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            reportFailure();
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > MAX_CYCLES) begin
            $display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
            reportFailure();
        end
    end

    function automatic logic [31:0] addrOf(input int tag, input int set, input int word);
        return 32'(tag * 64 + set * 16 + word * 4);
    endfunction

    function automatic logic [31:0] shadowWord(input logic [31:0] addr);
        return {shadow[{addr[9:2], 2'd3}], shadow[{addr[9:2], 2'd2}],
                shadow[{addr[9:2], 2'd1}], shadow[{addr[9:2], 2'd0}]};
    endfunction

    task automatic storeShadow(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] mask);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                shadow[{addr[9:2], 2'(b)}] = data[b*8 +: 8];
            end
        end
    endtask

    // Dirty lines are lost, so memory is the truth again
    task automatic reloadShadow;
        logic [31:0] a;
        for (int i = 0; i < 256; i++) begin
            a = 32'(i) << 2;
            storeShadow(a, busMem.peekWord(a), 4'hF);
        end
    endtask

    // Evicted words must match the shadow before the current store
    task automatic checkWriteBacks;
        logic [31:0] a;
        logic [31:0] d;
        while (busMem.logAddr.size() > 0) begin
            a = busMem.logAddr.pop_front();
            d = busMem.logData.pop_front();
            checkTrue(a < 32'd1024, "write-back address outside the bus memory");
            checkEq("writeBack", shadowWord(a), d);
        end
    endtask

    // ------------------------------
    // Processor side drivers
    // ------------------------------

    // Starts and ends one time unit after a rising edge
    task automatic doAccess(input string name, input logic [31:0] addr, input logic isWrite,
                            input logic [31:0] wData, input logic [3:0] mask,
                            output logic [31:0] rd, output int latency, output logic sawBus);
        logic [31:0] expRd;
        checkTrue(!stall, "stall high while the cache is idle");
        expRd            = shadowWord(addr);
        reqData.addr     = addr;
        reqData.wData    = wData;
        reqData.byteMask = mask;
        reqData.isWrite  = isWrite;
        req              = 1'b1;
        @(posedge clk);
        #1;
        req     = 1'b0;
        latency = 0;
        sawBus  = 1'b0;
        // Count cycles from acceptance until done
        do begin
            @(negedge clk);
            latency++;
            sawBus |= busRequest;
            // Stall covers every cycle of a miss up to its finish
            checkEq({name, "Stall"}, done ? 32'd0 : 32'd1, 32'(stall));
        end while (!done);
        rd = rdData;
        checkWriteBacks();
        if (isWrite) begin
            storeShadow(addr, wData, mask);
        end else begin
            checkEq(name, expRd, rd);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic pulseInvalidate;
        invalidate = 1'b1;
        @(posedge clk);
        #1;
        invalidate = 1'b0;
        reloadShadow();
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int          lat;
        int          tag;
        int          r;
        logic        bus;
        logic [31:0] a;
        logic [31:0] wd;
        logic [31:0] rd;
        logic [3:0]  m;
        seed       = 47;
        req        = 1'b0;
        invalidate = 1'b0;
        reqData    = '0;
        rstN       = 1'b0;
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;
        checkTrue(!stall && !done && !busRequest, "stall, done or busRequest high after reset");
        reloadShadow();

        // Cold miss, then a repeated read must hit in one cycle
        doAccess("firstRead", addrOf(3, 1, 2), 1'b0, '0, 4'hF, rd, lat, bus);
        checkTrue(bus, "first access after reset did not miss");
        doAccess("repeatRead", addrOf(3, 1, 2), 1'b0, '0, 4'hF, rd, lat, bus);
        checkEq("hitLatency", 32'd1, lat);
        checkEq("hitBusRequest", 32'd0, 32'(bus));

        // LRU in set 2 where A B A then C evicts B
        pulseInvalidate();
        doAccess("lruA", addrOf(4, 2, 0), 1'b0, '0, 4'hF, rd, lat, bus);
        doAccess("lruB", addrOf(5, 2, 0), 1'b0, '0, 4'hF, rd, lat, bus);
        doAccess("lruA", addrOf(4, 2, 0), 1'b0, '0, 4'hF, rd, lat, bus);
        doAccess("lruC", addrOf(6, 2, 0), 1'b0, '0, 4'hF, rd, lat, bus);
        doAccess("lruAHit", addrOf(4, 2, 0), 1'b0, '0, 4'hF, rd, lat, bus);
        checkEq("lruAHitLatency", 32'd1, lat);
        checkEq("lruAHitBusRequest", 32'd0, 32'(bus));
        doAccess("lruBMiss", addrOf(5, 2, 0), 1'b0, '0, 4'hF, rd, lat, bus);
        checkTrue(bus, "evicted line B did not miss");

        // Written data is dropped by invalidate
        a  = addrOf(4, 2, 1);
        wd = ~busMem.peekWord(a);
        doAccess("invWrite", a, 1'b1, wd, 4'hF, rd, lat, bus);
        doAccess("invReadBack", a, 1'b0, '0, 4'hF, rd, lat, bus);
        pulseInvalidate();
        doAccess("invRead", a, 1'b0, '0, 4'hF, rd, lat, bus);
        checkTrue(bus, "read after invalidate did not miss");
        checkEq("invReadMemory", busMem.peekWord(a), rd);

        // Random mix over 12 tags, so evictions are frequent
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            if ((r & 127) == 0) begin
                pulseInvalidate();
            end
            tag = ($random(seed) & 32'h7fff_ffff) % 12;
            a   = addrOf(tag, $random(seed) & 3, $random(seed) & 3);
            wd  = $random(seed);
            m   = r[4:1];
            if (m == 4'h0) begin
                m = 4'hF;
            end
            doAccess("randomAccess", a, r[0], wd, r[0] ? m : 4'hF, rd, lat, bus);
        end

        // Two unused tags per set push every line out
        for (int s = 0; s < NUM_SETS; s++) begin
            doAccess("sweepRead", addrOf(12, s, 0), 1'b0, '0, 4'hF, rd, lat, bus);
            doAccess("sweepRead", addrOf(13, s, 0), 1'b0, '0, 4'hF, rd, lat, bus);
        end
        for (int i = 0; i < 256; i++) begin
            a = 32'(i) << 2;
            checkEq("memoryCompare", shadowWord(a), busMem.peekWord(a));
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
verilog/dcachePkg.sv
verilog/dcacheTagStage.sv
verilog/dcacheController.sv
verilog/dcacheDataStage.sv
verilog/dcacheTop.sv
testbench/busMemModel.sv
testbench/dcacheTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the data cache testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -f build.f --top-module dcacheTb \
    --Mdir obj_dir -o dcacheSim > build.log 2>&1 \
    && ./obj_dir/dcacheSim > sim.log 2>&1

grep -qx "No errors" sim.log 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }
